//--- ar_issuer.sv
`timescale 1ns/10ps

module ar_issuer #(
  parameter int max_outstanding = 4
) (
  input  logic                    aclk,
  input  logic                    areset,
  input  logic                    launch,
  input  axi_rd_pkg::burst_plan_t plan,
  input  logic                    burst_drained,
  output logic                    m_axi_arvalid,
  output axi_rd_pkg::ar_req_t     m_axi_ar,
  input  logic                    m_axi_arready
);

  import axi_rd_pkg::*;

  // Vacancy runs from zero up to max_outstanding
  localparam int vac_w = $clog2(max_outstanding + 1);

  logic              arxfer;
  logic              idle;
  logic              last_burst;
  logic              ar_done;
  logic              stall;
  logic [addr_w-1:0] addr_r;

  assign arxfer  = m_axi_arvalid & m_axi_arready;
  assign ar_done = last_burst & arxfer;

  ////////////////////
  // Issue control
  ////////////////////

  // Idle until launch and again once the final burst is accepted
  always_ff @(posedge aclk) begin
    if (areset) begin
      idle <= 1'b1;
    end else if (launch) begin
      idle <= 1'b0;
    end else if (ar_done) begin
      idle <= 1'b1;
    end
  end

  // Valid drops on ready so at least one idle cycle separates requests
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_arvalid <= 1'b0;
    end else if (!idle && !stall && !m_axi_arvalid) begin
      m_axi_arvalid <= 1'b1;
    end else if (m_axi_arready) begin
      m_axi_arvalid <= 1'b0;
    end
  end

  // Step one full burst per accepted request
  always_ff @(posedge aclk) begin
    if (launch) begin
      addr_r <= plan.base;
    end else if (arxfer) begin
      addr_r <= addr_r + addr_w'(burst_bytes);
    end
  end

  // Short length only on the final burst
  assign m_axi_ar = '{
    addr: addr_r,
    len:  last_burst ? plan.final_len : log_burst_beats'(burst_beats - 1)
  };

  ////////////////////
  // Bookkeeping
  ////////////////////

  // Bursts left to request after the current one
  txn_counter #(
    .width (txn_w),
    .init  ('0)
  ) u_bursts_left (
    .aclk       (aclk),
    .areset     (areset),
    .load       (launch),
    .incr       (1'b0),
    .decr       (arxfer),
    .load_value (plan.full_bursts),
    .count      (),
    .is_zero    (last_burst)
  );

  // Free burst slots in the data FIFO
  // Stall AR when nothing is left
  txn_counter #(
    .width (vac_w),
    .init  (vac_w'(max_outstanding))
  ) u_vacancy (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_drained),
    .decr       (arxfer),
    .load_value ('0),
    .count      (),
    .is_zero    (stall)
  );

endmodule

//--- axi_rd_pkg.sv
package axi_rd_pkg;

  ////////////////////
  // Bus widths
  ////////////////////

  // Address and transfer size share one width
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // One beat carries four bytes
  localparam int beat_bytes     = data_w / 8;
  localparam int log_beat_bytes = $clog2(beat_bytes);

  // Burst limit is the smaller of 256 beats and 4 KB of data
  localparam int burst_beats     = 256;
  localparam int log_burst_beats = $clog2(burst_beats);
  localparam int burst_bytes     = burst_beats * beat_bytes;

  // Beat count minus one and its part above one burst
  localparam int total_len_w = addr_w - log_beat_bytes;
  localparam int txn_w       = total_len_w - log_burst_beats;

  ////////////////////
  // Payloads
  ////////////////////

  // Reduced AR request where len counts beats minus one
  typedef struct packed {
    logic [addr_w-1:0]          addr;
    logic [log_burst_beats-1:0] len;
  } ar_req_t;

  // Data beat on the R channel and on the stream
  typedef struct packed {
    logic [data_w-1:0] data;
    logic              last;
  } r_beat_t;

  // Transfer as prepared for the AR issuer and the R tracker
  typedef struct packed {
    logic [addr_w-1:0]          base;
    logic [txn_w-1:0]           full_bursts;
    logic [log_burst_beats-1:0] final_len;
  } burst_plan_t;

endpackage

//--- axi_read_master.sv
`timescale 1ns/10ps

module axi_read_master #(
  parameter int max_outstanding = 4
) (
  input  logic                          aclk,
  input  logic                          areset,
  // Control
  input  logic                          ctrl_start,
  input  logic [axi_rd_pkg::addr_w-1:0] ctrl_addr_offset,
  input  logic [axi_rd_pkg::addr_w-1:0] ctrl_xfer_size,
  output logic                          ctrl_done,
  // AR channel
  output logic                          m_axi_arvalid,
  output axi_rd_pkg::ar_req_t           m_axi_ar,
  input  logic                          m_axi_arready,
  // R channel
  input  logic                          m_axi_rvalid,
  input  axi_rd_pkg::r_beat_t           m_axi_r,
  output logic                          m_axi_rready,
  // Stream out
  output logic                          m_axis_tvalid,
  output axi_rd_pkg::r_beat_t           m_axis,
  input  logic                          m_axis_tready
);

  import axi_rd_pkg::*;

  // Room for every burst allowed in flight rounded up to a power of two
  localparam int fifo_depth = 2 ** $clog2(burst_beats * max_outstanding);

  burst_plan_t plan;
  logic        launch;
  logic        rxfer;
  logic        r_burst_end;
  logic        burst_drained;

  ////////////////////
  // Handshake strobes
  ////////////////////

  // FIFO never fills and R is always accepted
  assign m_axi_rready  = 1'b1;
  assign rxfer         = m_axi_rvalid & m_axi_rready;
  assign r_burst_end   = rxfer & m_axi_r.last;
  // A whole burst has left the stream and frees its FIFO slot
  assign burst_drained = m_axis_tvalid & m_axis_tready & m_axis.last;

  ////////////////////
  // Blocks
  ////////////////////

  xfer_setup u_setup (
    .aclk             (aclk),
    .areset           (areset),
    .ctrl_start       (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size   (ctrl_xfer_size),
    .launch           (launch),
    .plan             (plan)
  );

  ar_issuer #(
    .max_outstanding (max_outstanding)
  ) u_issuer (
    .aclk          (aclk),
    .areset        (areset),
    .launch        (launch),
    .plan          (plan),
    .burst_drained (burst_drained),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_ar      (m_axi_ar),
    .m_axi_arready (m_axi_arready)
  );

  // R beats in, stream beats out
  rd_data_fifo #(
    .depth (fifo_depth)
  ) u_fifo (
    .aclk     (aclk),
    .areset   (areset),
    .wr_en    (rxfer),
    .wr_beat  (m_axi_r),
    .rd_en    (m_axis_tready),
    .rd_valid (m_axis_tvalid),
    .rd_beat  (m_axis)
  );

  r_tracker u_tracker (
    .aclk        (aclk),
    .areset      (areset),
    .launch      (launch),
    .plan        (plan),
    .r_burst_end (r_burst_end),
    .ctrl_done   (ctrl_done)
  );

endmodule

//--- axi_read_master_asserts.sv
`timescale 1ns/10ps

module axi_read_master_asserts (
  input logic                aclk,
  input logic                areset,
  input logic                m_axi_arvalid,
  input axi_rd_pkg::ar_req_t m_axi_ar,
  input logic                m_axi_arready,
  input logic                m_axis_tvalid,
  input logic                ctrl_done
);

  // AR request holds until the slave takes it
  ar_hold: assert property (@(posedge aclk) disable iff (areset)
    m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_ar))
    else $error("AR valid or payload changed before ready");

  // Done is a single cycle strobe
  done_single: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |=> !ctrl_done)
    else $error("ctrl_done high for two cycles");

  // Registered outputs are cleared by reset
  reset_quiet: assert property (@(posedge aclk)
    areset |=> !m_axi_arvalid && !m_axis_tvalid && !ctrl_done)
    else $error("valid output high during reset");

endmodule

bind axi_read_master axi_read_master_asserts u_asserts (
  .aclk          (aclk),
  .areset        (areset),
  .m_axi_arvalid (m_axi_arvalid),
  .m_axi_ar      (m_axi_ar),
  .m_axi_arready (m_axi_arready),
  .m_axis_tvalid (m_axis_tvalid),
  .ctrl_done     (ctrl_done)
);

//--- r_tracker.sv
`timescale 1ns/10ps

module r_tracker (
  input  logic                    aclk,
  input  logic                    areset,
  input  logic                    launch,
  input  axi_rd_pkg::burst_plan_t plan,
  input  logic                    r_burst_end,
  output logic                    ctrl_done
);

  import axi_rd_pkg::*;

  logic final_burst;

  // Bursts still to arrive after the current one
  txn_counter #(
    .width (txn_w),
    .init  ('0)
  ) u_bursts_to_receive (
    .aclk       (aclk),
    .areset     (areset),
    .load       (launch),
    .incr       (1'b0),
    .decr       (r_burst_end),
    .load_value (plan.full_bursts),
    .count      (),
    .is_zero    (final_burst)
  );

  // One cycle pulse after the last beat of the final burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= r_burst_end & final_burst;
    end
  end

endmodule

//--- rd_data_fifo.sv
`timescale 1ns/10ps

module rd_data_fifo #(
  parameter int depth = 1024
) (
  input  logic                aclk,
  input  logic                areset,
  input  logic                wr_en,
  input  axi_rd_pkg::r_beat_t wr_beat,
  input  logic                rd_en,
  output logic                rd_valid,
  output axi_rd_pkg::r_beat_t rd_beat
);

  import axi_rd_pkg::*;

  localparam int aw = $clog2(depth);

  // Beat storage
  r_beat_t mem [depth];

  // Extra top bit tells full from empty
  logic [aw:0] wr_ptr;
  logic [aw:0] rd_ptr;
  logic        empty;
  logic        rd_fire;

  assign empty   = (wr_ptr == rd_ptr);
  assign rd_fire = rd_en & rd_valid;

  ////////////////////
  // Write side
  ////////////////////

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr[aw-1:0]] <= wr_beat;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  ////////////////////
  // Read side
  ////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      rd_ptr <= '0;
    end else if (rd_fire) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Head word falls through one cycle after its write
  assign rd_valid = ~empty;
  assign rd_beat  = mem[rd_ptr[aw-1:0]];

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f vlog.f \
       --top-module tb_axi_read_master -o sim_tb \
  && ./obj_dir/sim_tb \
  || exit 1

//--- tb_axi_read_master.sv
`timescale 1ns/10ps

module tb_axi_read_master;

  import axi_rd_pkg::*;

  // Request with tready pattern per 32 cycle slot and expected beats and bursts
  typedef struct packed {
    logic [31:0] offset;
    logic [31:0] size;
    logic [7:0]  ready_pat;
    logic [31:0] beats;
    logic [31:0] bursts;
  } row_t;

  localparam int          n_rows     = 5;
  localparam int          max_out    = 4;
  localparam logic [31:0] align_mask = 32'hFFFF_FC00;

  row_t rows [n_rows] = '{
    '{32'h0000_1234, 32'd1,    8'hFF, 32'd1,    32'd1},
    '{32'h0002_0000, 32'd4,    8'h55, 32'd1,    32'd1},
    '{32'h0000_53FF, 32'd100,  8'hAA, 32'd25,   32'd1},
    '{32'h0010_0A00, 32'd5000, 8'hF3, 32'd1250, 32'd5},
    // Long tready stalls push AR against the outstanding limit
    '{32'h0040_0000, 32'd8192, 8'h01, 32'd2048, 32'd8}
  };

  logic        aclk;
  logic        areset;
  logic        ctrl_start;
  logic [31:0] ctrl_addr_offset;
  logic [31:0] ctrl_xfer_size;
  logic        ctrl_done;
  logic        m_axi_arvalid;
  ar_req_t     m_axi_ar;
  logic        m_axi_arready;
  logic        m_axi_rvalid;
  r_beat_t     m_axi_r;
  logic        m_axi_rready;
  logic        m_axis_tvalid;
  r_beat_t     m_axis;
  logic        m_axis_tready;

  row_t cur;
  int   ar_count;
  int   r_count;
  int   beat_count;
  int   done_count;
  int   ar_total;
  int   drained_total;
  int   cycles;
  int   limit;
  int   phase;

  always #50 aclk = ~aclk;

  axi_read_master #(.max_outstanding (max_out)) dut (.*);

  tb_axi_slave_model u_slave (
    .aclk    (aclk),
    .areset  (areset),
    .arvalid (m_axi_arvalid),
    .ar      (m_axi_ar),
    .arready (m_axi_arready),
    .rvalid  (m_axi_rvalid),
    .r       (m_axi_r),
    .rready  (m_axi_rready)
  );

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic fail_now(input string what);
    $display("Error at %0t: %s", $time, what);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  ////////////////////
  // Bus monitors
  ////////////////////

  always @(posedge aclk) begin
    if (!areset) begin
      // R is always accepted
      check("m_axi_rready", {31'b0, m_axi_rready}, 32'd1);
      // AR steps by one burst and only the final one is short
      if (m_axi_arvalid && m_axi_arready) begin
        if (ar_count >= cur.bursts) fail_now("AR request beyond the expected burst count");
        check("m_axi_ar.addr", m_axi_ar.addr,
              (cur.offset & align_mask) + 32'(ar_count) * 32'd1024);
        if (ar_count == cur.bursts - 1)
          check("m_axi_ar.len", {24'b0, m_axi_ar.len}, (cur.beats - 32'd1) & 32'hFF);
        else
          check("m_axi_ar.len", {24'b0, m_axi_ar.len}, 32'd255);
        ar_count++;
        ar_total++;
      end
      if (m_axi_rvalid && m_axi_rready) r_count++;
      // Done only once every R beat is in
      if (ctrl_done) begin
        done_count++;
        check("r_beats_at_done", r_count, cur.beats);
      end
      if (m_axis_tvalid && m_axis_tready) begin
        if (beat_count >= cur.beats) fail_now("stream beat beyond the expected count");
        check("m_axis.data", m_axis.data, (cur.offset & align_mask) + 32'(beat_count) * 32'd4);
        check("m_axis.last", {31'b0, m_axis.last},
              {31'b0, ((beat_count + 1) % 256 == 0) || (beat_count + 1 == cur.beats)});
        if (m_axis.last) drained_total++;
        beat_count++;
      end
      if (ar_total - drained_total > max_out) fail_now("more than four bursts in flight");
    end
  end

  // Stream back-pressure from the row pattern
  always @(posedge aclk) begin
    if (areset) begin
      m_axis_tready <= 1'b0;
      phase         <= 0;
    end else begin
      m_axis_tready <= cur.ready_pat[phase[7:5]];
      phase         <= phase + 1;
    end
  end

  always @(posedge aclk) begin
    cycles++;
    if (cycles > limit) fail_now($sformatf("no progress, timeout after %0d cycles", cycles));
  end

  ////////////////////
  // Request sequence
  ////////////////////

  initial begin
    aclk = 1'b0;
    areset = 1'b1;
    ctrl_start = 1'b0;
    ctrl_addr_offset = '0;
    ctrl_xfer_size = '0;
    m_axis_tready = 1'b0;
    cur = '0;
    ar_total = 0;
    drained_total = 0;
    cycles = 0;
    limit = 0;
    for (int i = 0; i < n_rows; i++) limit += 20 * int'(rows[i].beats) + 200;
    repeat (3) @(posedge aclk);
    areset <= 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      // Next row is set up between clock edges while the bus is quiet
      @(negedge aclk);
      cur = rows[i];
      ar_count = 0;
      r_count = 0;
      beat_count = 0;
      done_count = 0;
      @(posedge aclk);
      ctrl_start       <= 1'b1;
      ctrl_addr_offset <= cur.offset;
      ctrl_xfer_size   <= cur.size;
      @(posedge aclk);
      ctrl_start <= 1'b0;
      do @(negedge aclk); while (done_count == 0);
      // FIFO may still hold data after done
      do @(negedge aclk); while (beat_count < cur.beats);
      repeat (4) @(negedge aclk);
      check("ar_count", ar_count, cur.bursts);
      check("done_count", done_count, 32'd1);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- tb_axi_slave_model.sv
`timescale 1ns/10ps

module tb_axi_slave_model (
  input  logic                aclk,
  input  logic                areset,
  input  logic                arvalid,
  input  axi_rd_pkg::ar_req_t ar,
  output logic                arready,
  output logic                rvalid,
  output axi_rd_pkg::r_beat_t r,
  input  logic                rready
);

  import axi_rd_pkg::*;

  // Accepted requests answered in order
  ar_req_t     pending [$];
  ar_req_t     req;
  logic [31:0] rng;
  logic [31:0] next_addr;
  int          beats_left;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial begin
    rng        = 32'h620db5eb;
    next_addr  = '0;
    beats_left = 0;
    arready    = 1'b0;
    rvalid     = 1'b0;
    r          = '0;
  end

  always @(posedge aclk) begin
    if (areset) begin
      arready    <= 1'b0;
      rvalid     <= 1'b0;
      beats_left = 0;
      pending.delete();
    end else begin
      rng = xorshift(rng);
      if (arvalid && arready) begin
        pending.push_back(ar);
      end
      // Ready three cycles out of four
      arready <= (rng[1:0] != 2'b00);
      // Next burst once every beat of the current one has been shown
      if (beats_left == 0 && pending.size() > 0) begin
        req        = pending.pop_front();
        next_addr  = req.addr;
        beats_left = int'(req.len) + 1;
      end
      // Slot is free when no beat is shown or the shown one was taken
      if (!rvalid || rready) begin
        if (beats_left > 0 && rng[4:2] != 3'b000) begin
          // Data is the byte address of the beat
          rvalid     <= 1'b1;
          r          <= '{data: next_addr, last: (beats_left == 1)};
          next_addr  = next_addr + 32'd4;
          beats_left = beats_left - 1;
        end else begin
          rvalid <= 1'b0;
        end
      end
    end
  end

endmodule

//--- txn_counter.sv
`timescale 1ns/10ps

module txn_counter #(
  parameter int               width = 8,
  parameter logic [width-1:0] init  = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [width-1:0] load_value,
  output logic [width-1:0] count,
  output logic             is_zero
);

  // Load wins over counting
  // Increment and decrement in one cycle leave the count alone
  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= init;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + 1'b1;
    end else if (decr && !incr) begin
      count <= count - 1'b1;
    end
  end

  // Flag taken straight from the register
  assign is_zero = (count == '0);

endmodule

//--- vlog.f
axi_rd_pkg.sv
txn_counter.sv
xfer_setup.sv
ar_issuer.sv
rd_data_fifo.sv
r_tracker.sv
axi_read_master.sv
axi_read_master_asserts.sv
tb_axi_slave_model.sv
tb_axi_read_master.sv

//--- xfer_setup.sv
`timescale 1ns/10ps

module xfer_setup (
  input  logic                      aclk,
  input  logic                      areset,
  input  logic                      ctrl_start,
  input  logic [axi_rd_pkg::addr_w-1:0] ctrl_addr_offset,
  input  logic [axi_rd_pkg::addr_w-1:0] ctrl_xfer_size,
  output logic                      launch,
  output axi_rd_pkg::burst_plan_t   plan
);

  import axi_rd_pkg::*;

  // Bits below one full burst
  localparam logic [addr_w-1:0] addr_mask = addr_w'(burst_bytes - 1);

  logic                   start_d1;
  logic [addr_w-1:0]      base_r;
  logic [total_len_w-1:0] total_len_r;

  ////////////////////
  // Start strobe delay
  ////////////////////

  // Stage one captures the request and stage two builds the plan
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      launch   <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      launch   <= start_d1;
    end
  end

  ////////////////////
  // Request capture
  ////////////////////

  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Align down to a burst boundary
      base_r <= ctrl_addr_offset & ~addr_mask;
      // Beats minus one with a partial beat counted as a whole one
      if (ctrl_xfer_size[log_beat_bytes-1:0] != '0) begin
        total_len_r <= ctrl_xfer_size[addr_w-1:log_beat_bytes];
      end else begin
        total_len_r <= ctrl_xfer_size[addr_w-1:log_beat_bytes] - 1'b1;
      end
    end
  end

  // Split into full bursts and the length of the final one
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      plan.base        <= base_r;
      plan.full_bursts <= total_len_r[total_len_w-1:log_burst_beats];
      plan.final_len   <= total_len_r[log_burst_beats-1:0];
    end
  end

endmodule
